//--- hdl/bpred_pkg.sv
package bpred_pkg;

    ////////////////////
    // Fetch address
    ////////////////////
    localparam int unsigned pc_width     = 32;
    localparam int unsigned offset_width = 2;   // Byte within a 4-byte slot

    ////////////////////
    // Table geometry
    ////////////////////
    localparam int unsigned bht_sets      = 512;
    localparam int unsigned index_width   = 9;
    localparam int unsigned slot_width    = 2;
    localparam int unsigned slots_per_set = 4;
    localparam int unsigned counter_width = 2;  // Four slots pack into 8 bits
    localparam int unsigned set_width     = slots_per_set * counter_width;

    // Tag is whatever remains above index, slot and offset
    localparam int unsigned tag_width =
        pc_width - index_width - slot_width - offset_width;

    ////////////////////
    // Helpers
    ////////////////////
    // Bit positions of the address fields
    localparam int unsigned index_lsb = offset_width + slot_width;
    localparam int unsigned tag_lsb   = index_lsb + index_width;

    // Saturation limit of one counter
    localparam int unsigned counter_max = (1 << counter_width) - 1;

    // Status counter
    localparam int unsigned miss_count_width = 32;

endpackage

//--- hdl/bht.sv
`timescale 1ns/1ps

module bht (
    input  logic                                   clock,
    input  logic                                   reset_n,

    input  logic                                   write_enable,
    input  logic [bpred_pkg::index_width-1:0]      write_index,
    input  logic [bpred_pkg::slot_width-1:0]       write_slot,
    input  logic                                   write_inc,
    input  logic                                   write_dec,

    input  logic                                   read_enable,
    input  logic [bpred_pkg::index_width-1:0]      read_index,
    output logic [bpred_pkg::set_width-1:0]        read_data,
    output logic                                   read_valid,
    output logic [bpred_pkg::miss_count_width-1:0] read_miss_count
);

    import bpred_pkg::*;

    logic [set_width-1:0] counters   [bht_sets];
    logic                 valid_bits [bht_sets];

    logic [set_width-1:0] write_set;  // Set contents after training
    logic                 bypass;

    // Saturating step of one counter inside a set
    function automatic logic [set_width-1:0] train_set(
        input logic [set_width-1:0]  set_in,
        input logic [slot_width-1:0] slot,
        input logic                  inc,
        input logic                  dec
    );
        logic [set_width-1:0]     set_out;
        logic [counter_width-1:0] count;
        set_out = set_in;
        count   = set_in[slot*counter_width +: counter_width];
        if (inc && !dec) begin
            if (count != counter_max[counter_width-1:0]) begin
                count = count + 1'b1;
            end
        end else if (dec && !inc) begin
            if (count != '0) begin
                count = count - 1'b1;
            end
        end
        // Both or neither leaves the counter alone
        set_out[slot*counter_width +: counter_width] = count;
        return set_out;
    endfunction

    assign write_set = train_set(counters[write_index], write_slot, write_inc, write_dec);
    assign bypass    = write_enable && (write_index == read_index);

    ////////////////////
    // Table storage
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < bht_sets; i++) begin
                counters[i]   <= '0;
                valid_bits[i] <= 1'b0;
            end
        end else if (write_enable) begin
            counters[write_index]   <= write_set;
            valid_bits[write_index] <= 1'b1;  // Every update trains the set
        end
    end

    ////////////////////
    // Read port
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_data       <= '0;
            read_valid      <= 1'b0;
            read_miss_count <= '0;
        end else if (read_enable) begin
            if (bypass) begin
                // Same set written this edge
                read_data  <= write_set;
                read_valid <= 1'b1;
            end else begin
                read_data  <= counters[read_index];
                read_valid <= valid_bits[read_index];
            end

            // Miss is judged on the stored valid bit
            if (!valid_bits[read_index]) begin
                read_miss_count <= read_miss_count + 1'b1;
            end
        end
    end

    // Outputs hold while read_enable is low

endmodule

//--- hdl/btb.sv
`timescale 1ns/1ps

module btb (
    input  logic                              clock,
    input  logic                              reset_n,

    input  logic                              write_enable,
    input  logic [bpred_pkg::index_width-1:0] write_index,
    input  logic [bpred_pkg::tag_width-1:0]   write_tag,
    input  logic [bpred_pkg::pc_width-1:0]    write_target,

    input  logic                              read_enable,
    input  logic [bpred_pkg::index_width-1:0] read_index,
    output logic                              read_valid,
    output logic [bpred_pkg::tag_width-1:0]   read_tag,
    output logic [bpred_pkg::pc_width-1:0]    read_target
);

    import bpred_pkg::*;

    logic [tag_width-1:0] tags       [bht_sets];
    logic [pc_width-1:0]  targets    [bht_sets];
    logic                 valid_bits [bht_sets];

    logic bypass;

    assign bypass = write_enable && (write_index == read_index);

    ////////////////////
    // Valid bits
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < bht_sets; i++) begin
                valid_bits[i] <= 1'b0;
            end
        end else if (write_enable) begin
            valid_bits[write_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_valid <= 1'b0;
        end else if (read_enable) begin
            read_valid <= bypass ? 1'b1 : valid_bits[read_index];
        end
    end

    ////////////////////
    // Tag and target
    ////////////////////
    always_ff @(posedge clock) begin
        if (write_enable) begin
            tags[write_index]    <= write_tag;
            targets[write_index] <= write_target;
        end

        if (read_enable) begin
            if (bypass) begin
                read_tag    <= write_tag;     // Forward the entry being written
                read_target <= write_target;
            end else begin
                read_tag    <= tags[read_index];
                read_target <= targets[read_index];
            end
        end
    end

endmodule

//--- hdl/bpred_ctrl.sv
`timescale 1ns/1ps

module bpred_ctrl (
    input  logic                              clock,
    input  logic                              reset_n,

    input  logic                              pred_valid,
    input  logic [bpred_pkg::pc_width-1:0]    pred_pc,
    output logic                              pred_ready,

    output logic                              resp_valid,
    input  logic                              resp_ready,
    output logic                              resp_taken,
    output logic                              resp_hit,
    output logic [bpred_pkg::pc_width-1:0]    resp_target,

    input  logic                              upd_valid,
    input  logic [bpred_pkg::pc_width-1:0]    upd_pc,
    input  logic                              upd_taken,
    input  logic [bpred_pkg::pc_width-1:0]    upd_target,
    output logic                              upd_ready,

    output logic                              bht_write_enable,
    output logic [bpred_pkg::index_width-1:0] bht_write_index,
    output logic [bpred_pkg::slot_width-1:0]  bht_write_slot,
    output logic                              bht_write_inc,
    output logic                              bht_write_dec,
    output logic                              bht_read_enable,
    output logic [bpred_pkg::index_width-1:0] bht_read_index,
    input  logic [bpred_pkg::set_width-1:0]   bht_read_data,
    input  logic                              bht_set_valid,

    output logic                              btb_write_enable,
    output logic [bpred_pkg::index_width-1:0] btb_write_index,
    output logic [bpred_pkg::tag_width-1:0]   btb_write_tag,
    output logic [bpred_pkg::pc_width-1:0]    btb_write_target,
    output logic                              btb_read_enable,
    output logic [bpred_pkg::index_width-1:0] btb_read_index,
    input  logic                              btb_entry_valid,
    input  logic [bpred_pkg::tag_width-1:0]   btb_entry_tag,
    input  logic [bpred_pkg::pc_width-1:0]    btb_entry_target
);

    import bpred_pkg::*;

    logic                     active;      // High from the first edge after reset
    logic                     pred_fire;
    logic                     upd_fire;
    logic [tag_width-1:0]     req_tag_q;
    logic [slot_width-1:0]    req_slot_q;
    logic [counter_width-1:0] slot_counter;

    ////////////////////
    // Handshakes
    ////////////////////
    assign pred_ready = active && (!resp_valid || resp_ready);
    assign upd_ready  = active;
    assign pred_fire  = pred_valid && pred_ready;
    assign upd_fire   = upd_valid && upd_ready;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            active     <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            active <= 1'b1;
            if (pred_fire) begin
                resp_valid <= 1'b1;       // Fixed one-cycle latency
            end else if (resp_ready) begin
                resp_valid <= 1'b0;
            end
        end
    end

    // Request fields kept for the returning table data
    always_ff @(posedge clock) begin
        if (pred_fire) begin
            req_tag_q  <= pred_pc[tag_lsb +: tag_width];
            req_slot_q <= pred_pc[offset_width +: slot_width];
        end
    end

    ////////////////////
    // Table access
    ////////////////////
    assign bht_read_enable  = pred_fire;  // Low read enable holds the outputs
    assign bht_read_index   = pred_pc[index_lsb +: index_width];
    assign btb_read_enable  = pred_fire;
    assign btb_read_index   = pred_pc[index_lsb +: index_width];

    assign bht_write_enable = upd_fire;
    assign bht_write_index  = upd_pc[index_lsb +: index_width];
    assign bht_write_slot   = upd_pc[offset_width +: slot_width];
    assign bht_write_inc    = upd_taken;
    assign bht_write_dec    = !upd_taken;

    // Only taken branches install a target
    assign btb_write_enable = upd_fire && upd_taken;
    assign btb_write_index  = upd_pc[index_lsb +: index_width];
    assign btb_write_tag    = upd_pc[tag_lsb +: tag_width];
    assign btb_write_target = upd_target;

    ////////////////////
    // Prediction
    ////////////////////
    always_comb begin
        slot_counter = '0;
        for (int s = 0; s < slots_per_set; s++) begin
            if (req_slot_q == slot_width'(s)) begin
                slot_counter = bht_read_data[s*counter_width +: counter_width];
            end
        end
    end

    assign resp_hit    = btb_entry_valid && (btb_entry_tag == req_tag_q);
    assign resp_taken  = resp_hit && bht_set_valid && slot_counter[counter_width-1];
    assign resp_target = resp_hit ? btb_entry_target : '0;

endmodule

//--- hdl/bpred_top.sv
`timescale 1ns/1ps

module bpred_top (
    input  logic                                   clock,
    input  logic                                   reset_n,

    input  logic                                   pred_valid,
    input  logic [bpred_pkg::pc_width-1:0]         pred_pc,
    output logic                                   pred_ready,

    output logic                                   resp_valid,
    input  logic                                   resp_ready,
    output logic                                   resp_taken,
    output logic                                   resp_hit,
    output logic [bpred_pkg::pc_width-1:0]         resp_target,

    input  logic                                   upd_valid,
    input  logic [bpred_pkg::pc_width-1:0]         upd_pc,
    input  logic                                   upd_taken,
    input  logic [bpred_pkg::pc_width-1:0]         upd_target,
    output logic                                   upd_ready,

    output logic [bpred_pkg::miss_count_width-1:0] read_miss_count
);

    import bpred_pkg::*;

    // Control to BHT
    logic                   bht_write_enable;
    logic [index_width-1:0] bht_write_index;
    logic [slot_width-1:0]  bht_write_slot;
    logic                   bht_write_inc;
    logic                   bht_write_dec;
    logic                   bht_read_enable;
    logic [index_width-1:0] bht_read_index;
    logic [set_width-1:0]   bht_read_data;
    logic                   bht_set_valid;

    // Control to BTB
    logic                   btb_write_enable;
    logic [index_width-1:0] btb_write_index;
    logic [tag_width-1:0]   btb_write_tag;
    logic [pc_width-1:0]    btb_write_target;
    logic                   btb_read_enable;
    logic [index_width-1:0] btb_read_index;
    logic                   btb_entry_valid;
    logic [tag_width-1:0]   btb_entry_tag;
    logic [pc_width-1:0]    btb_entry_target;

    bpred_ctrl i_ctrl (
        .clock            (clock),
        .reset_n          (reset_n),
        .pred_valid       (pred_valid),
        .pred_pc          (pred_pc),
        .pred_ready       (pred_ready),
        .resp_valid       (resp_valid),
        .resp_ready       (resp_ready),
        .resp_taken       (resp_taken),
        .resp_hit         (resp_hit),
        .resp_target      (resp_target),
        .upd_valid        (upd_valid),
        .upd_pc           (upd_pc),
        .upd_taken        (upd_taken),
        .upd_target       (upd_target),
        .upd_ready        (upd_ready),
        .bht_write_enable (bht_write_enable),
        .bht_write_index  (bht_write_index),
        .bht_write_slot   (bht_write_slot),
        .bht_write_inc    (bht_write_inc),
        .bht_write_dec    (bht_write_dec),
        .bht_read_enable  (bht_read_enable),
        .bht_read_index   (bht_read_index),
        .bht_read_data    (bht_read_data),
        .bht_set_valid    (bht_set_valid),
        .btb_write_enable (btb_write_enable),
        .btb_write_index  (btb_write_index),
        .btb_write_tag    (btb_write_tag),
        .btb_write_target (btb_write_target),
        .btb_read_enable  (btb_read_enable),
        .btb_read_index   (btb_read_index),
        .btb_entry_valid  (btb_entry_valid),
        .btb_entry_tag    (btb_entry_tag),
        .btb_entry_target (btb_entry_target)
    );

    bht i_bht (
        .clock           (clock),
        .reset_n         (reset_n),
        .write_enable    (bht_write_enable),
        .write_index     (bht_write_index),
        .write_slot      (bht_write_slot),
        .write_inc       (bht_write_inc),
        .write_dec       (bht_write_dec),
        .read_enable     (bht_read_enable),
        .read_index      (bht_read_index),
        .read_data       (bht_read_data),
        .read_valid      (bht_set_valid),
        .read_miss_count (read_miss_count)  // Straight to the status port
    );

    btb i_btb (
        .clock        (clock),
        .reset_n      (reset_n),
        .write_enable (btb_write_enable),
        .write_index  (btb_write_index),
        .write_tag    (btb_write_tag),
        .write_target (btb_write_target),
        .read_enable  (btb_read_enable),
        .read_index   (btb_read_index),
        .read_valid   (btb_entry_valid),
        .read_tag     (btb_entry_tag),
        .read_target  (btb_entry_target)
    );

endmodule

//--- tb/bpred_tb.sv
`timescale 1ns/1ps

module bpred_tb;

    import bpred_pkg::*;

    localparam int unsigned cycle_limit = 4000;  // About ten times the sequence

    logic                        clock;
    logic                        reset_n;
    logic                        pred_valid;
    logic [pc_width-1:0]         pred_pc;
    logic                        pred_ready;
    logic                        resp_valid;
    logic                        resp_ready;
    logic                        resp_taken;
    logic                        resp_hit;
    logic [pc_width-1:0]         resp_target;
    logic                        upd_valid;
    logic [pc_width-1:0]         upd_pc;
    logic                        upd_taken;
    logic [pc_width-1:0]         upd_target;
    logic                        upd_ready;
    logic [miss_count_width-1:0] read_miss_count;

    // A present key in the model means the set or entry is valid
    bit [7:0]    model_sets    [int];
    bit [18:0]   model_tags    [int];
    bit [31:0]   model_targets [int];
    int unsigned model_misses = 0;

    // Expected response of the request in flight
    logic        exp_taken;
    logic        exp_hit;
    logic [31:0] exp_target;
    logic [31:0] exp_misses;

    int unsigned cycle_count = 0;
    int unsigned sent_count = 0;
    int unsigned done_count = 0;
    int unsigned error_count = 0;
    int unsigned tests_passed = 0;
    int unsigned tests_failed = 0;
    int unsigned errors_at_start = 0;
    bit          throttle = 1'b0;  // Random stalls on resp_ready

    bpred_top i_dut (
        .clock           (clock),
        .reset_n         (reset_n),
        .pred_valid      (pred_valid),
        .pred_pc         (pred_pc),
        .pred_ready      (pred_ready),
        .resp_valid      (resp_valid),
        .resp_ready      (resp_ready),
        .resp_taken      (resp_taken),
        .resp_hit        (resp_hit),
        .resp_target     (resp_target),
        .upd_valid       (upd_valid),
        .upd_pc          (upd_pc),
        .upd_taken       (upd_taken),
        .upd_target      (upd_target),
        .upd_ready       (upd_ready),
        .read_miss_count (read_miss_count)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
        end
        $display("ERROR: run did not finish within %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    always begin : resp_ready_drive
        @(posedge clock);
        #10;
        resp_ready = throttle ? ($urandom_range(0, 2) == 0) : 1'b1;
    end

    ////////////////////
    // Model
    ////////////////////
    // Slot is bits 3..2, index 12..4, tag 31..13
    function automatic int field_index(input logic [31:0] pc);
        return int'(pc[12:4]);
    endfunction

    function automatic int field_slot(input logic [31:0] pc);
        return int'(pc[3:2]);
    endfunction

    function automatic bit [18:0] field_tag(input logic [31:0] pc);
        return pc[31:13];
    endfunction

    function automatic bit [7:0] model_set(input int index);
        return model_sets.exists(index) ? model_sets[index] : 8'h00;
    endfunction

    always @(posedge clock) begin : model_step
        int       index;
        bit       miss;
        bit [1:0] count;
        bit [7:0] set;
        if (reset_n) begin
            if (resp_valid && resp_ready) begin
                done_count++;
            end
            // Miss is judged before a same-edge update
            miss = pred_valid && pred_ready && !model_sets.exists(field_index(pred_pc));

            if (upd_valid && upd_ready) begin
                index = field_index(upd_pc);
                set   = model_set(index);
                count = set[field_slot(upd_pc)*2 +: 2];
                if (upd_taken && count != 2'd3) begin
                    count++;
                end else if (!upd_taken && count != 2'd0) begin
                    count--;
                end
                set[field_slot(upd_pc)*2 +: 2] = count;
                model_sets[index] = set;
                if (upd_taken) begin
                    model_tags[index]    = field_tag(upd_pc);
                    model_targets[index] = upd_target;
                end
            end

            if (pred_valid && pred_ready) begin
                index   = field_index(pred_pc);
                exp_hit = 1'b0;
                if (model_targets.exists(index)) begin
                    exp_hit = (model_tags[index] == field_tag(pred_pc));
                end
                set        = model_set(index);
                count      = set[field_slot(pred_pc)*2 +: 2];
                exp_taken  = exp_hit && model_sets.exists(index) && count[1];
                exp_target = exp_hit ? model_targets[index] : 32'h0;
                if (miss) begin
                    model_misses++;
                end
                exp_misses = model_misses;
                sent_count++;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    assert property (@(posedge clock) disable iff (!reset_n)
        resp_valid && resp_ready |-> resp_taken == exp_taken)
    else begin
        error_count++;
        $display("MISMATCH resp_taken expected %h actual %h",
                 $sampled(exp_taken), $sampled(resp_taken));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        resp_valid && resp_ready |-> resp_hit == exp_hit)
    else begin
        error_count++;
        $display("MISMATCH resp_hit expected %h actual %h",
                 $sampled(exp_hit), $sampled(resp_hit));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        resp_valid && resp_ready |-> resp_target == exp_target)
    else begin
        error_count++;
        $display("MISMATCH resp_target expected %h actual %h",
                 $sampled(exp_target), $sampled(resp_target));
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        resp_valid && resp_ready |-> read_miss_count == exp_misses)
    else begin
        error_count++;
        $display("MISMATCH read_miss_count expected %h actual %h",
                 $sampled(exp_misses), $sampled(read_miss_count));
    end

    // Response follows an accepted request after one cycle
    assert property (@(posedge clock) disable iff (!reset_n)
        pred_valid && pred_ready |=> resp_valid)
    else begin
        error_count++;
        $display("ERROR: no response one cycle after an accepted request");
    end

    // Stalled response holds and blocks new requests
    assert property (@(posedge clock) disable iff (!reset_n)
        resp_valid && !resp_ready |-> !pred_ready)
    else begin
        error_count++;
        $display("ERROR: pred_ready is high while the response is stalled");
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_taken)
            && $stable(resp_hit) && $stable(resp_target))
    else begin
        error_count++;
        $display("ERROR: response changed while it was stalled");
    end

    ////////////////////
    // Stimulus tasks
    ////////////////////
    // Called 10 ns after a rising edge, returns 10 ns after the transfer edge
    task automatic send_predict(input logic [31:0] pc);
        pred_valid = 1'b1;
        pred_pc    = pc;
        @(negedge clock);
        while (!pred_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        #10;
        pred_valid = 1'b0;
    endtask

    task automatic send_update(input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
        upd_valid  = 1'b1;
        upd_pc     = pc;
        upd_taken  = taken;
        upd_target = target;
        @(negedge clock);
        while (!upd_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        #10;
        upd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (done_count != sent_count) begin
            @(posedge clock);
            #10;
        end
    endtask

    task automatic finish_test(input string name);
        wait_idle();
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    function automatic logic [31:0] random_pc();
        logic [18:0] tag;
        tag = ($urandom_range(0, 1) == 0) ? 19'h00011 : 19'h00022;
        return {tag, 9'h040 + 9'($urandom_range(0, 3)), 2'($urandom_range(0, 3)), 2'b00};
    endfunction

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        int unsigned t0;
        int unsigned kind;
        void'($urandom(1352));
        reset_n    = 1'b0;
        pred_valid = 1'b0;
        pred_pc    = '0;
        resp_ready = 1'b0;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        upd_target = '0;

        // Cold state
        repeat (5) begin
            @(posedge clock);
            #10;
            assert (!resp_valid && !pred_ready && !upd_ready)
            else begin
                error_count++;
                $display("ERROR: handshake output is high during reset");
            end
        end
        reset_n = 1'b1;
        @(posedge clock);
        #10;
        assert (pred_ready && upd_ready)
        else begin
            error_count++;
            $display("ERROR: ready is low on the first edge after reset");
        end
        for (int k = 1; k <= 4; k++) begin
            send_predict({19'(k), 9'(k * 16), 2'(k), 2'b00});  // Untrained sets
        end
        finish_test("cold_state");

        // Training and saturation on slot 1
        pc_a = {19'h0002B, 9'h1A3, 2'd1, 2'b00};
        for (int k = 0; k < 4; k++) begin
            send_update(pc_a, 1'b1, 32'h0000_8A40);
            send_predict(pc_a);
        end
        for (int k = 0; k < 5; k++) begin
            send_update(pc_a, 1'b0, 32'h0);
            send_predict(pc_a);
        end
        send_update(pc_a, 1'b1, 32'h0000_8A40);
        send_predict(pc_a);                       // One above the floor
        finish_test("training_saturation");

        // Other slots and an aliasing tag
        send_update(pc_a, 1'b1, 32'h0000_8A40);
        send_update(pc_a, 1'b1, 32'h0000_8A40);
        for (int s = 0; s < 4; s++) begin
            send_predict({19'h0002B, 9'h1A3, 2'(s), 2'b00});
        end
        send_predict({19'h0005C, 9'h1A3, 2'd1, 2'b00});
        finish_test("slots_and_tags");

        // Update and request on one set at one edge
        pc_b = {19'h00033, 9'h0C7, 2'd2, 2'b00};
        for (int k = 0; k < 4; k++) begin
            fork
                send_update(pc_b, k != 3, 32'h0001_2000 + 32'(k));
                send_predict(pc_b);
            join
        end
        finish_test("write_bypass");

        // Stalls, then full rate
        throttle = 1'b1;
        for (int k = 0; k < 12; k++) begin
            send_predict((k % 2 == 0) ? pc_a : pc_b);
        end
        wait_idle();
        throttle = 1'b0;
        @(posedge clock);
        #10;
        t0 = cycle_count;
        for (int k = 0; k < 8; k++) begin
            send_predict((k % 2 == 0) ? pc_b : pc_a);
        end
        assert (cycle_count - t0 == 8)
        else begin
            error_count++;
            $display("ERROR: back-to-back requests took %0d cycles for 8", cycle_count - t0);
        end
        finish_test("backpressure_full_rate");

        // Random mix over four sets and two tags
        throttle = 1'b1;
        for (int n = 0; n < 200; n++) begin
            pc_a = random_pc();
            pc_b = random_pc();
            kind = $urandom_range(0, 2);
            if (kind == 0) begin
                send_predict(pc_a);
            end else if (kind == 1) begin
                send_update(pc_b, $urandom_range(0, 1), $urandom);
            end else begin
                fork
                    send_predict(pc_a);
                    send_update(pc_b, $urandom_range(0, 1), $urandom);
                join
            end
        end
        throttle = 1'b0;
        finish_test("random_mix");

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
hdl/bpred_pkg.sv
hdl/bht.sv
hdl/btb.sv
hdl/bpred_ctrl.sv
hdl/bpred_top.sv
tb/bpred_tb.sv

//--- Bender.yml
package:
  name: bpred

sources:
  - hdl/bpred_pkg.sv
  - hdl/bht.sv
  - hdl/btb.sv
  - hdl/bpred_ctrl.sv
  - hdl/bpred_top.sv
  - target: test
    files:
      - tb/bpred_tb.sv
